// ==== verilog.f ====
rtl/dcache_pkg.sv
rtl/refill_if.sv
rtl/cache_array.sv
rtl/miss_queue.sv
rtl/dcache.sv
dv/mem_model.sv
dv/dcache_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps -j 0
TOP       = dcache_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with $(TOOL) and run it"
	@echo "  clean  remove $(BUILD_DIR)"

# the run passes only if the pass line shows up in the output
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
  import dcache_pkg::*;

  localparam int num_ways       = 4;
  localparam int num_sets       = 32 / num_ways;
  localparam int return_timeout = 100;
  localparam int settle_cycles  = 24;
  localparam logic [63:0] data_factor = 64'h9e37_79b9_7f4a_7c15;

  // op_miss also waits for the return and reads again
  typedef enum {op_read, op_miss, op_miss_only, op_write, op_wait, op_count} op_t;

  logic         clock = 1'b0;
  logic         reset;
  logic         rd_en;
  addr_t        rd_addr;
  word_t        rd_data;
  logic         rd_valid;
  logic         wr_en;
  addr_t        wr_addr;
  word_t        wr_data;
  addr_t        rd_miss_addr;
  word_t        rd_miss_data;
  logic         rd_miss_valid;
  bus_command_t mem_command;
  addr_t        mem_addr;
  mem_tag_t     mem_response;
  word_t        mem_rd_data;
  mem_tag_t     mem_rd_tag;
  int           load_count;
  int           hold_errors;

  op_t   row_op   [$];
  addr_t row_addr [$];
  word_t row_data [$];
  addr_t returned_addr [$];
  word_t returned_data [$];
  int    pulse_count = 0;
  int    loads_mark  = 0;
  int    pulses_mark = 0;

  always #4 clock = ~clock;

  dcache #(
    .num_ways    (num_ways),
    .queue_depth (4)
  ) dut_i (
    .clock         (clock),
    .reset         (reset),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_miss_addr  (rd_miss_addr),
    .rd_miss_data  (rd_miss_data),
    .rd_miss_valid (rd_miss_valid),
    .mem_command   (mem_command),
    .mem_addr      (mem_addr),
    .mem_response  (mem_response),
    .mem_rd_data   (mem_rd_data),
    .mem_rd_tag    (mem_rd_tag)
  );

  mem_model mem_i (
    .clock        (clock),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_rd_tag   (mem_rd_tag),
    .mem_rd_data  (mem_rd_data),
    .load_count   (load_count),
    .hold_errors  (hold_errors)
  );

  //////////////////////////////////////////////////////////////////////
  // reference rules and reporting
  //////////////////////////////////////////////////////////////////////

  function automatic addr_t block_addr(input int block);
    return addr_t'(block * 8);
  endfunction

  function automatic addr_t aligned(input addr_t addr);
    return {16'h0000, addr[15:3], 3'b000};
  endfunction

  function automatic word_t memory_word(input addr_t addr);
    return 64'(addr[15:3]) * data_factor;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail at %0t: %s, got %h, expected %h",
                                  $time, what, actual, expected));
    end
  endtask

  // a miss return is captured at the edge that also writes the fill
  always @(posedge clock) begin
    if (!reset && rd_miss_valid) begin
      returned_addr.push_back(rd_miss_addr);
      returned_data.push_back(rd_miss_data);
      pulse_count++;
    end
  end

  always @(posedge clock) begin
    if (hold_errors != 0) begin
      stop_with_failure("memory bus request changed before it was accepted");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic add_row(input op_t op, input addr_t addr, input word_t data);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_data.push_back(data);
  endtask

  task automatic build_table();
    add_row(op_miss, 32'h0105, '0);
    add_row(op_read, 32'h0100, memory_word(32'h0100));
    add_row(op_count, '0, 64'd1);
    // write allocate without a load
    add_row(op_write, 32'h0208, 64'h0123_4567_89ab_cdef);
    add_row(op_read, 32'h0208, 64'h0123_4567_89ab_cdef);
    add_row(op_count, '0, 64'd0);
    // write lands while the miss is still out
    add_row(op_miss_only, 32'h0310, '0);
    add_row(op_write, 32'h0310, 64'hfeed_0000_beef_0001);
    add_row(op_wait, 32'h0310, '0);
    add_row(op_read, 32'h0310, 64'hfeed_0000_beef_0001);
    // later fills into set 2 must not push out the written line
    for (int t = 1; t < num_ways; t++) begin
      add_row(op_miss, block_addr(t * num_sets + 2), '0);
    end
    add_row(op_read, 32'h0310, 64'hfeed_0000_beef_0001);
    add_row(op_count, '0, 64'(num_ways));
    // back to back misses to one block
    add_row(op_miss_only, 32'h0418, '0);
    add_row(op_miss_only, 32'h0418, '0);
    add_row(op_wait, 32'h0418, '0);
    add_row(op_read, 32'h0418, memory_word(32'h0418));
    add_row(op_count, '0, 64'd1);
    // num_ways + 1 blocks into set 5 evict the first one
    for (int t = 1; t <= num_ways + 1; t++) begin
      add_row(op_miss, block_addr(t * num_sets + 5), '0);
    end
    for (int t = 2; t <= num_ways + 1; t++) begin
      add_row(op_read, block_addr(t * num_sets + 5), memory_word(block_addr(t * num_sets + 5)));
    end
    add_row(op_miss, block_addr(num_sets + 5), '0);
    add_row(op_count, '0, 64'(num_ways + 2));
    // several in flight return in issue order
    add_row(op_miss_only, 32'h0530, '0);
    add_row(op_miss_only, 32'h0638, '0);
    add_row(op_miss_only, 32'h0740, '0);
    add_row(op_wait, 32'h0530, '0);
    add_row(op_wait, 32'h0638, '0);
    add_row(op_wait, 32'h0740, '0);
    add_row(op_count, '0, 64'd3);
  endtask

  task automatic set_idle();
    rd_en   = 1'b0;
    rd_addr = '0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
  endtask

  task automatic read_expect_hit(input addr_t addr, input word_t data);
    rd_en   = 1'b1;
    rd_addr = addr;
    #1;
    check_value(64'(rd_valid), 64'd1, $sformatf("rd_valid on read of %h", addr));
    check_value(rd_data, data, $sformatf("rd_data on read of %h", addr));
  endtask

  task automatic read_expect_miss(input addr_t addr);
    rd_en   = 1'b1;
    rd_addr = addr;
    #1;
    check_value(64'(rd_valid), 64'd0, $sformatf("rd_valid on missing read of %h", addr));
  endtask

  task automatic check_return(input addr_t addr);
    int    cycles;
    addr_t got_addr;
    word_t got_data;
    cycles = 0;
    while (returned_addr.size() == 0) begin
      if (cycles == return_timeout) begin
        stop_with_failure($sformatf("no miss return for %h within %0d cycles",
                                    addr, return_timeout));
      end
      @(negedge clock);
      cycles++;
    end
    got_addr = returned_addr.pop_front();
    got_data = returned_data.pop_front();
    check_value(64'(got_addr), 64'(aligned(addr)), "rd_miss_addr");
    check_value(got_data, memory_word(addr), $sformatf("rd_miss_data for %h", addr));
  endtask

  task automatic check_counts(input word_t expected);
    repeat (settle_cycles) @(negedge clock);
    check_value(64'(load_count - loads_mark), expected, "loads accepted by memory");
    check_value(64'(pulse_count - pulses_mark), expected, "rd_miss_valid pulses");
    loads_mark  = load_count;
    pulses_mark = pulse_count;
  endtask

  initial begin
    reset = 1'b1;
    set_idle();
    build_table();
    repeat (3) @(negedge clock);
    reset = 1'b0;
    #1;
    check_value(64'(rd_valid), 64'd0, "rd_valid after reset");
    check_value(64'(rd_miss_valid), 64'd0, "rd_miss_valid after reset");
    check_value(64'(mem_command), 64'(bus_none), "mem_command after reset");

    for (int i = 0; i < row_op.size(); i++) begin
      @(negedge clock);
      set_idle();
      case (row_op[i])
        op_read:      read_expect_hit(row_addr[i], row_data[i]);
        op_miss_only: read_expect_miss(row_addr[i]);
        op_wait:      check_return(row_addr[i]);
        op_count:     check_counts(row_data[i]);
        op_write: begin
          wr_en   = 1'b1;
          wr_addr = row_addr[i];
          wr_data = row_data[i];
        end
        op_miss: begin
          read_expect_miss(row_addr[i]);
          @(negedge clock);
          set_idle();
          check_return(row_addr[i]);
          @(negedge clock);
          read_expect_hit(row_addr[i], memory_word(row_addr[i]));
        end
        default: stop_with_failure("unknown operation in the table");
      endcase
    end

    @(negedge clock);
    set_idle();
    if (returned_addr.size() != 0) begin
      stop_with_failure("rd_miss_valid pulsed for a read that was never waited on");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== dv/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model (
  input  logic                     clock,
  input  dcache_pkg::bus_command_t mem_command,
  input  dcache_pkg::addr_t        mem_addr,
  output dcache_pkg::mem_tag_t     mem_response,
  output dcache_pkg::mem_tag_t     mem_rd_tag,
  output dcache_pkg::word_t        mem_rd_data,
  output int                       load_count,
  output int                       hold_errors
);
  import dcache_pkg::*;

  // contents of a block are its block address times this odd constant
  localparam logic [63:0] data_factor = 64'h9e37_79b9_7f4a_7c15;

  logic [15:0] lfsr        = 16'd9;
  int          cycle       = 0;
  int          stall_left  = 0;
  int          last_due    = 0;
  int          due         = 0;
  int          loads       = 0;
  int          errors      = 0;
  logic        busy        = 1'b0;
  addr_t       held_addr   = '0;
  addr_t       popped_addr = '0;
  time         first_seen  = 0;
  mem_tag_t    next_tag    = 4'd1;
  mem_tag_t    response_q  = '0;
  mem_tag_t    rd_tag_q    = '0;
  word_t       rd_data_q   = '0;

  // accepted loads waiting for their return, oldest first
  mem_tag_t ret_tag  [$];
  addr_t    ret_addr [$];
  int       ret_due  [$];

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic int take_bits(input int count);
    int value;
    value = 0;
    for (int b = 0; b < count; b++) begin
      lfsr  = lfsr_next(lfsr);
      value = value * 2 + int'(lfsr[0]);
    end
    return value;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // accept side
  //////////////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    cycle++;
    response_q = '0;
    if (mem_command == bus_load) begin
      if (!busy) begin
        busy       = 1'b1;
        held_addr  = mem_addr;
        first_seen = $time;
        stall_left = take_bits(2);
      end else if (mem_addr !== held_addr) begin
        errors++;
        $display("mem_addr moved from %h to %h, first on the bus at %0t",
                 held_addr, mem_addr, first_seen);
      end
      if (stall_left > 0) begin
        stall_left--;
      end else begin
        response_q = next_tag;
        ret_tag.push_back(next_tag);
        ret_addr.push_back(held_addr);
        // in order, never two returns in one cycle
        due = cycle + 2 + take_bits(3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        ret_due.push_back(due);
        next_tag = (next_tag == 4'd15) ? 4'd1 : mem_tag_t'(next_tag + 4'd1);
        loads++;
        busy = 1'b0;
      end
    end else if (busy) begin
      errors++;
      $display("load request for %h was withdrawn before it was accepted", held_addr);
    end

    ////////////////////////////////////////////////////////////////////
    // return side
    ////////////////////////////////////////////////////////////////////

    rd_tag_q = '0;
    if (ret_due.size() > 0 && cycle >= ret_due[0]) begin
      void'(ret_due.pop_front());
      rd_tag_q    = ret_tag.pop_front();
      popped_addr = ret_addr.pop_front();
      rd_data_q   = 64'(popped_addr[offset_bits +: block_bits]) * data_factor;
    end
  end

  assign mem_response = response_q;
  assign mem_rd_tag   = rd_tag_q;
  assign mem_rd_data  = rd_data_q;
  assign load_count   = loads;
  assign hold_errors  = errors;

endmodule

`default_nettype wire

// ==== rtl/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache #(
  parameter int num_ways    = 4,
  parameter int queue_depth = 4
) (
  input  logic                      clock,
  input  logic                      reset,

  // processor read port
  input  logic                      rd_en,
  input  dcache_pkg::addr_t         rd_addr,
  output dcache_pkg::word_t         rd_data,
  output logic                      rd_valid,

  // processor write port
  input  logic                      wr_en,
  input  dcache_pkg::addr_t         wr_addr,
  input  dcache_pkg::word_t         wr_data,

  // miss return
  output dcache_pkg::addr_t         rd_miss_addr,
  output dcache_pkg::word_t         rd_miss_data,
  output logic                      rd_miss_valid,

  // memory bus
  output dcache_pkg::bus_command_t  mem_command,
  output dcache_pkg::addr_t         mem_addr,
  input  dcache_pkg::mem_tag_t      mem_response,
  input  dcache_pkg::word_t         mem_rd_data,
  input  dcache_pkg::mem_tag_t      mem_rd_tag
);

  refill_if refill_i ();

  cache_array #(
    .num_ways (num_ways)
  ) array_i (
    .clock    (clock),
    .reset    (reset),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .refill   (refill_i.array)
  );

  miss_queue #(
    .queue_depth (queue_depth)
  ) queue_i (
    .clock         (clock),
    .reset         (reset),
    .mem_command   (mem_command),
    .mem_addr      (mem_addr),
    .mem_response  (mem_response),
    .mem_rd_tag    (mem_rd_tag),
    .mem_rd_data   (mem_rd_data),
    .rd_miss_addr  (rd_miss_addr),
    .rd_miss_data  (rd_miss_data),
    .rd_miss_valid (rd_miss_valid),
    .refill        (refill_i.queue)
  );

endmodule

`default_nettype wire

// ==== rtl/miss_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_queue #(
  parameter int queue_depth = 4
) (
  input  logic                      clock,
  input  logic                      reset,
  output dcache_pkg::bus_command_t  mem_command,
  output dcache_pkg::addr_t         mem_addr,
  input  dcache_pkg::mem_tag_t      mem_response,
  input  dcache_pkg::mem_tag_t      mem_rd_tag,
  input  dcache_pkg::word_t         mem_rd_data,
  output dcache_pkg::addr_t         rd_miss_addr,
  output dcache_pkg::word_t         rd_miss_data,
  output logic                      rd_miss_valid,
  refill_if.queue                   refill
);
  import dcache_pkg::*;

  localparam int ptr_bits = (queue_depth > 1) ? $clog2(queue_depth) : 1;

  typedef logic [ptr_bits-1:0] ptr_t;

  //////////////////////////////////////////////////////////////////////
  // queue state
  //////////////////////////////////////////////////////////////////////

  logic [queue_depth-1:0] entry_valid;
  logic [queue_depth-1:0] entry_accepted;
  block_t                 entry_block [queue_depth];
  mem_tag_t               entry_tag   [queue_depth];

  // head is the oldest entry, issue the oldest not yet accepted
  ptr_t head;
  ptr_t issue;
  ptr_t tail;

  logic pending;
  logic accept;
  logic ret_match;
  logic duplicate;
  logic full;
  logic alloc;

  // registered miss return, also the fill pulse
  logic   ret_valid;
  block_t ret_block;
  word_t  ret_data;

  function automatic ptr_t next_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(queue_depth - 1)) ? '0 : ptr_t'(ptr + 1'b1);
  endfunction

  function automatic addr_t block_to_addr(input block_t block);
    return addr_t'({block, {offset_bits{1'b0}}});
  endfunction

  //////////////////////////////////////////////////////////////////////
  // allocation
  //////////////////////////////////////////////////////////////////////

  // merge with anything queued or returning right now
  always_comb begin
    duplicate = ret_valid && ret_block == refill.lookup_block;
    for (int i = 0; i < queue_depth; i++) begin
      if (entry_valid[i] && entry_block[i] == refill.lookup_block) begin
        duplicate = 1'b1;
      end
    end
  end

  // entries stay in order, so a valid tail slot means full
  assign full  = entry_valid[tail];
  assign alloc = refill.lookup_miss && !full && !duplicate;

  //////////////////////////////////////////////////////////////////////
  // bus issue and return
  //////////////////////////////////////////////////////////////////////

  assign pending = entry_valid[issue] && !entry_accepted[issue];
  assign accept  = pending && mem_response != '0;

  assign mem_command = pending ? bus_load : bus_none;
  assign mem_addr    = pending ? block_to_addr(entry_block[issue]) : '0;

  // returns come back in acceptance order, so only the head can match
  assign ret_match = entry_valid[head] && entry_accepted[head] &&
                     mem_rd_tag != '0 && mem_rd_tag == entry_tag[head];

  assign rd_miss_valid = ret_valid;
  assign rd_miss_addr  = block_to_addr(ret_block);
  assign rd_miss_data  = ret_data;

  assign refill.fill_valid = ret_valid;
  assign refill.fill_block = ret_block;
  assign refill.fill_data  = ret_data;

  //////////////////////////////////////////////////////////////////////
  // control registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid    <= '0;
      entry_accepted <= '0;
      head           <= '0;
      issue          <= '0;
      tail           <= '0;
      ret_valid      <= 1'b0;
    end else begin
      if (alloc) begin
        entry_valid[tail]    <= 1'b1;
        entry_accepted[tail] <= 1'b0;
        tail                 <= next_ptr(tail);
      end
      if (accept) begin
        entry_accepted[issue] <= 1'b1;
        issue                 <= next_ptr(issue);
      end
      // retire the head as its data is registered
      if (ret_match) begin
        entry_valid[head] <= 1'b0;
        head              <= next_ptr(head);
      end
      ret_valid <= ret_match;
    end
  end

  // payload
  always_ff @(posedge clock) begin
    if (alloc) begin
      entry_block[tail] <= refill.lookup_block;
    end
    if (accept) begin
      entry_tag[issue] <= mem_response;
    end
    if (ret_match) begin
      ret_block <= entry_block[head];
      ret_data  <= mem_rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_array #(
  parameter int num_ways = 4
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              rd_en,
  input  dcache_pkg::addr_t rd_addr,
  output dcache_pkg::word_t rd_data,
  output logic              rd_valid,
  input  logic              wr_en,
  input  dcache_pkg::addr_t wr_addr,
  input  dcache_pkg::word_t wr_data,
  refill_if.array           refill
);
  import dcache_pkg::*;

  localparam int num_sets   = 32 / num_ways;
  localparam int index_bits = $clog2(num_sets);
  localparam int tag_bits   = block_bits - index_bits;
  localparam int way_bits   = (num_ways > 1) ? $clog2(num_ways) : 1;

  typedef logic [index_bits-1:0] index_t;
  typedef logic [tag_bits-1:0]   tag_t;
  typedef logic [way_bits-1:0]   way_t;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  logic [num_ways-1:0] line_valid [num_sets];
  tag_t                line_tag   [num_sets][num_ways];
  word_t               line_data  [num_sets][num_ways];
  // next way to replace in each set
  way_t                victim     [num_sets];

  block_t rd_block;
  block_t wr_block;
  index_t rd_index;
  index_t wr_index;
  index_t fill_index;
  tag_t   rd_tag;
  tag_t   wr_tag;
  tag_t   fill_tag;

  logic              rd_hit;
  way_t              rd_way;
  logic              wr_hit;
  way_t              wr_hit_way;
  way_t              wr_way;
  logic [way_bits:0] fill_probe;
  logic              fill_hit;
  logic              fill_en;
  way_t              fill_way;

  // returns {hit, way} for one set
  function automatic logic [way_bits:0] probe(input index_t idx, input tag_t tag);
    logic hit;
    way_t way;
    hit = 1'b0;
    way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (!hit && line_valid[idx][w] && line_tag[idx][w] == tag) begin
        hit = 1'b1;
        way = way_t'(w);
      end
    end
    return {hit, way};
  endfunction

  function automatic way_t next_way(input way_t way);
    return (way == way_t'(num_ways - 1)) ? '0 : way_t'(way + 1'b1);
  endfunction

  assign rd_block   = rd_addr[offset_bits +: block_bits];
  assign wr_block   = wr_addr[offset_bits +: block_bits];
  assign rd_index   = rd_block[index_bits-1:0];
  assign rd_tag     = rd_block[block_bits-1:index_bits];
  assign wr_index   = wr_block[index_bits-1:0];
  assign wr_tag     = wr_block[block_bits-1:index_bits];
  assign fill_index = refill.fill_block[index_bits-1:0];
  assign fill_tag   = refill.fill_block[block_bits-1:index_bits];

  //////////////////////////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    {rd_hit, rd_way}     = probe(rd_index, rd_tag);
    {wr_hit, wr_hit_way} = probe(wr_index, wr_tag);
    fill_probe           = probe(fill_index, fill_tag);
  end

  assign rd_valid = rd_en && rd_hit;
  assign rd_data  = rd_hit ? line_data[rd_index][rd_way] : '0;

  assign refill.lookup_miss  = rd_en && !rd_hit;
  assign refill.lookup_block = rd_block;

  // write allocates at the victim on a miss
  assign wr_way = wr_hit ? wr_hit_way : victim[wr_index];

  // fill loses to a present block or a write into the same set
  assign fill_hit = fill_probe[way_bits];
  assign fill_en  = refill.fill_valid && !fill_hit && !(wr_en && wr_index == fill_index);
  assign fill_way = victim[fill_index];

  //////////////////////////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        line_valid[s] <= '0;
        victim[s]     <= '0;
      end
    end else begin
      if (wr_en) begin
        line_valid[wr_index][wr_way] <= 1'b1;
        if (!wr_hit) begin
          victim[wr_index] <= next_way(victim[wr_index]);
        end
      end
      if (fill_en) begin
        line_valid[fill_index][fill_way] <= 1'b1;
        victim[fill_index]               <= next_way(fill_way);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      line_tag[wr_index][wr_way]  <= wr_tag;
      line_data[wr_index][wr_way] <= wr_data;
    end
    if (fill_en) begin
      line_tag[fill_index][fill_way]  <= fill_tag;
      line_data[fill_index][fill_way] <= refill.fill_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/refill_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface refill_if;
  import dcache_pkg::*;

  // read miss seen by the array
  logic   lookup_miss;
  block_t lookup_block;

  // one-cycle fill pulse from the queue, always accepted
  logic   fill_valid;
  block_t fill_block;
  word_t  fill_data;

  modport array (
    output lookup_miss,
    output lookup_block,
    input  fill_valid,
    input  fill_block,
    input  fill_data
  );

  modport queue (
    input  lookup_miss,
    input  lookup_block,
    output fill_valid,
    output fill_block,
    output fill_data
  );

endinterface

`default_nettype wire

// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

  //////////////////////////////////////////////////////////////////////
  // address layout
  //////////////////////////////////////////////////////////////////////

  // block address is byte address bits 15:3
  localparam int block_bits = 13;

  // byte offset inside one 8-byte word
  localparam int offset_bits = 3;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // one cache line holds one data word
  typedef logic [63:0] word_t;

  // processor and memory bus byte address
  typedef logic [31:0] addr_t;

  typedef logic [block_bits-1:0] block_t;

  // zero means no tag, or request not accepted
  typedef logic [3:0] mem_tag_t;

  //////////////////////////////////////////////////////////////////////
  // memory bus
  //////////////////////////////////////////////////////////////////////

  // store is part of the bus encoding but never issued here
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_command_t;

endpackage

`default_nettype wire
